//--- manycore_pkg.sv
/*
 * shared definitions for the manycore column slice
 * network widths, credit and buffer sizing
 * packet opcode and request/response payload types
 */

package manycore_pkg;

  // network widths
  localparam int data_width_lp    = 32;
  localparam int addr_width_lp    = 10;  // word address
  localparam int load_id_width_lp = 4;
  localparam int mask_width_lp    = data_width_lp / 8;

  // words in the tile data memory
  localparam int dmem_words_lp = 1 << addr_width_lp;

  // flow control
  localparam int max_credits_lp = 4;
  localparam int fifo_depth_lp  = max_credits_lp;  // no buffer can overflow

  // derived counter widths
  localparam int credit_width_lp     = $clog2(max_credits_lp + 1);
  localparam int fifo_ptr_width_lp   = $clog2(fifo_depth_lp);
  localparam int fifo_count_width_lp = $clog2(fifo_depth_lp + 1);

  typedef enum logic [0:0] {
    op_store = 1'b0,
    op_load  = 1'b1
  } packet_op_e;

  // request packet, 51 bits
  typedef struct packed {
    packet_op_e                  op;
    logic [addr_width_lp-1:0]    addr;
    logic [data_width_lp-1:0]    data;
    logic [mask_width_lp-1:0]    mask;
    logic [load_id_width_lp-1:0] load_id;
  } manycore_req_s;

  // response packet, 37 bits
  typedef struct packed {
    packet_op_e                  op;
    logic [data_width_lp-1:0]    data;
    logic [load_id_width_lp-1:0] load_id;
  } manycore_resp_s;

endpackage

//--- manycore_packet_fifo.sv
/*
 * valid/ready packet buffer with a type-parameter payload
 * circular buffer, fixed depth from the package
 */

module manycore_packet_fifo
  import manycore_pkg::*;
#(
  parameter type payload_t = manycore_req_s
) (
  input  logic     clk,
  input  logic     rst_i,

  input  logic     v_i,
  input  payload_t data_i,
  output logic     ready_o,

  output logic     v_o,
  output payload_t data_o,
  input  logic     yumi_i
);

  payload_t mem_r [0:fifo_depth_lp-1];

  logic [fifo_ptr_width_lp-1:0]   wr_ptr_r;
  logic [fifo_ptr_width_lp-1:0]   rd_ptr_r;
  logic [fifo_count_width_lp-1:0] count_r;

  logic full;
  logic push;
  logic pop;

  assign full    = (count_r == fifo_count_width_lp'(fifo_depth_lp));
  assign ready_o = ~full | yumi_i;  // full buffer still takes a push on a pop
  assign push    = v_i & ready_o;
  assign pop     = yumi_i;

  assign v_o    = (count_r != '0);
  assign data_o = mem_r[rd_ptr_r];

  always_ff @(posedge clk) begin
    if (push) begin
      mem_r[wr_ptr_r] <= data_i;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      wr_ptr_r <= '0;
      rd_ptr_r <= '0;
      count_r  <= '0;
    end else begin
      if (push) wr_ptr_r <= wr_ptr_r + 1'b1;  // depth is a power of two
      if (pop)  rd_ptr_r <= rd_ptr_r + 1'b1;
      case ({push, pop})
        2'b10:   count_r <= count_r + 1'b1;
        2'b01:   count_r <= count_r - 1'b1;
        default: count_r <= count_r;
      endcase
    end
  end

  // a packet offered to a full buffer needs a pop in the same cycle
  a_no_push_full: assert property (@(posedge clk) disable iff (rst_i)
    (v_i && full) |-> yumi_i);

  // consumer may only pop what it has seen valid
  a_no_pop_empty: assert property (@(posedge clk) disable iff (rst_i)
    yumi_i |-> v_o);

endmodule

//--- manycore_io_loader.sv
/*
 * host-side loader
 * forms request packets from host commands, assigns load ids,
 * counts credits and returns load data to the host in order
 */

module manycore_io_loader
  import manycore_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_i,

  input  logic                        cmd_v_i,
  input  packet_op_e                  cmd_op_i,
  input  logic [addr_width_lp-1:0]    cmd_addr_i,
  input  logic [data_width_lp-1:0]    cmd_data_i,
  input  logic [mask_width_lp-1:0]    cmd_mask_i,
  output logic                        cmd_ready_o,

  output logic                        req_v_o,
  output manycore_req_s               req_data_o,
  input  logic                        req_ready_i,

  input  logic                        resp_v_i,
  input  manycore_resp_s              resp_data_i,
  output logic                        resp_ready_o,

  output logic                        resp_v_o,
  output logic [data_width_lp-1:0]    resp_data_o,
  output logic [load_id_width_lp-1:0] resp_load_id_o
);

  logic [credit_width_lp-1:0]  credit_r;
  logic [load_id_width_lp-1:0] load_id_r;

  logic          out_v_r;
  manycore_req_s out_data_r;

  logic                        host_v_r;
  logic [data_width_lp-1:0]    host_data_r;
  logic [load_id_width_lp-1:0] host_id_r;

  logic cmd_accept;

  // free credit and the output register empty or draining
  assign cmd_ready_o = (credit_r != '0) & (~out_v_r | req_ready_i);
  assign cmd_accept  = cmd_v_i & cmd_ready_o;

  assign req_v_o    = out_v_r;
  assign req_data_o = out_data_r;

  assign resp_ready_o = 1'b1;  // responses are never stalled

  always_ff @(posedge clk) begin
    if (rst_i) begin
      out_v_r <= 1'b0;
    end else if (cmd_accept) begin
      out_v_r <= 1'b1;
    end else if (req_ready_i) begin
      out_v_r <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (cmd_accept) begin
      out_data_r <= '{
        op:      cmd_op_i,
        addr:    cmd_addr_i,
        data:    cmd_data_i,
        mask:    cmd_mask_i,
        load_id: (cmd_op_i == op_load) ? load_id_r : '0
      };
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      credit_r  <= credit_width_lp'(max_credits_lp);
      load_id_r <= '0;
    end else begin
      case ({cmd_accept, resp_v_i})
        2'b10:   credit_r <= credit_r - 1'b1;
        2'b01:   credit_r <= credit_r + 1'b1;
        default: credit_r <= credit_r;
      endcase
      if (cmd_accept && cmd_op_i == op_load) begin
        load_id_r <= load_id_r + 1'b1;  // wraps mod 16
      end
    end
  end

  // store acks only return a credit
  always_ff @(posedge clk) begin
    if (rst_i) begin
      host_v_r <= 1'b0;
    end else begin
      host_v_r <= resp_v_i & (resp_data_i.op == op_load);
    end
  end

  always_ff @(posedge clk) begin
    if (resp_v_i) begin
      host_data_r <= resp_data_i.data;
      host_id_r   <= resp_data_i.load_id;
    end
  end

  assign resp_v_o       = host_v_r;
  assign resp_data_o    = host_data_r;
  assign resp_load_id_o = host_id_r;

  a_credit_bound: assert property (@(posedge clk) disable iff (rst_i)
    credit_r <= credit_width_lp'(max_credits_lp));

  // every response must answer a packet still in flight
  a_resp_outstanding: assert property (@(posedge clk) disable iff (rst_i)
    resp_v_i |-> (credit_r != credit_width_lp'(max_credits_lp)));

endmodule

//--- manycore_tile_endpoint.sv
/*
 * tile endpoint
 * word-addressed data memory with byte-masked stores
 * one response per request, held under back-pressure
 */

module manycore_tile_endpoint
  import manycore_pkg::*;
(
  input  logic           clk,
  input  logic           rst_i,

  input  logic           req_v_i,
  input  manycore_req_s  req_data_i,
  output logic           req_yumi_o,

  output logic           resp_v_o,
  output manycore_resp_s resp_data_o,
  input  logic           resp_ready_i
);

  logic [data_width_lp-1:0] mem_r [0:dmem_words_lp-1];

  logic                        resp_v_r;
  packet_op_e                  resp_op_r;
  logic [load_id_width_lp-1:0] resp_id_r;
  logic [data_width_lp-1:0]    rd_data_r;

  logic resp_free;
  logic take;

  // response slot empty or leaving this cycle
  assign resp_free  = ~resp_v_r | resp_ready_i;
  assign take       = req_v_i & resp_free;
  assign req_yumi_o = take;

  // synchronous read, masked byte write
  always_ff @(posedge clk) begin
    if (take) begin
      rd_data_r <= mem_r[req_data_i.addr];  // old word on a store
      if (req_data_i.op == op_store) begin
        for (int i = 0; i < mask_width_lp; i++) begin
          if (req_data_i.mask[i]) begin
            mem_r[req_data_i.addr][8*i +: 8] <= req_data_i.data[8*i +: 8];
          end
        end
      end
    end
  end

  always_ff @(posedge clk) begin
    if (take) begin
      resp_op_r <= req_data_i.op;
      resp_id_r <= req_data_i.load_id;
    end
  end

  always_ff @(posedge clk) begin
    if (rst_i) begin
      resp_v_r <= 1'b0;
    end else if (take) begin
      resp_v_r <= 1'b1;
    end else if (resp_ready_i) begin
      resp_v_r <= 1'b0;
    end
  end

  assign resp_v_o    = resp_v_r;
  assign resp_data_o = '{
    op:      resp_op_r,
    data:    rd_data_r,
    load_id: resp_id_r
  };

  // a request left waiting behind a held response stays put until taken
  a_req_stable: assert property (@(posedge clk) disable iff (rst_i)
    (req_v_i && !req_yumi_o) |=> (req_v_i && $stable(req_data_i)));

endmodule

//--- manycore_link_top.sv
/*
 * column slice top level
 * loader, request and response buffers, tile endpoint
 */

module manycore_link_top
  import manycore_pkg::*;
(
  input  logic                        clk,
  input  logic                        rst_i,

  input  logic                        cmd_v_i,
  input  packet_op_e                  cmd_op_i,
  input  logic [addr_width_lp-1:0]    cmd_addr_i,
  input  logic [data_width_lp-1:0]    cmd_data_i,
  input  logic [mask_width_lp-1:0]    cmd_mask_i,
  output logic                        cmd_ready_o,

  output logic                        resp_v_o,
  output logic [data_width_lp-1:0]    resp_data_o,
  output logic [load_id_width_lp-1:0] resp_load_id_o
);

  // request link
  logic           req_v;
  manycore_req_s  req_data;
  logic           req_ready;
  logic           ep_req_v;
  manycore_req_s  ep_req_data;
  logic           ep_req_yumi;

  // response link
  logic           resp_v;
  manycore_resp_s resp_data;
  logic           resp_ready;
  logic           ld_resp_v;
  manycore_resp_s ld_resp_data;
  logic           ld_resp_ready;

  wire ld_resp_yumi = ld_resp_v & ld_resp_ready;

  manycore_io_loader i_loader (
    .clk            (clk),
    .rst_i          (rst_i),
    .cmd_v_i        (cmd_v_i),
    .cmd_op_i       (cmd_op_i),
    .cmd_addr_i     (cmd_addr_i),
    .cmd_data_i     (cmd_data_i),
    .cmd_mask_i     (cmd_mask_i),
    .cmd_ready_o    (cmd_ready_o),
    .req_v_o        (req_v),
    .req_data_o     (req_data),
    .req_ready_i    (req_ready),
    .resp_v_i       (ld_resp_yumi),
    .resp_data_i    (ld_resp_data),
    .resp_ready_o   (ld_resp_ready),
    .resp_v_o       (resp_v_o),
    .resp_data_o    (resp_data_o),
    .resp_load_id_o (resp_load_id_o)
  );

  manycore_packet_fifo #(
    .payload_t (manycore_req_s)
  ) i_req_fifo (
    .clk     (clk),
    .rst_i   (rst_i),
    .v_i     (req_v),
    .data_i  (req_data),
    .ready_o (req_ready),
    .v_o     (ep_req_v),
    .data_o  (ep_req_data),
    .yumi_i  (ep_req_yumi)
  );

  manycore_tile_endpoint i_endpoint (
    .clk          (clk),
    .rst_i        (rst_i),
    .req_v_i      (ep_req_v),
    .req_data_i   (ep_req_data),
    .req_yumi_o   (ep_req_yumi),
    .resp_v_o     (resp_v),
    .resp_data_o  (resp_data),
    .resp_ready_i (resp_ready)
  );

  manycore_packet_fifo #(
    .payload_t (manycore_resp_s)
  ) i_resp_fifo (
    .clk     (clk),
    .rst_i   (rst_i),
    .v_i     (resp_v),
    .data_i  (resp_data),
    .ready_o (resp_ready),
    .v_o     (ld_resp_v),
    .data_o  (ld_resp_data),
    .yumi_i  (ld_resp_yumi)
  );

endmodule

//--- tb_clock_gen.sv
/*
 * testbench clock source
 * free-running clock, period 8
 */

module tb_clock_gen (
  output logic clk_o
);

  initial begin
    clk_o = 1'b0;
  end

  always #4 clk_o = ~clk_o;  // half period

endmodule

//--- tb_manycore_link.sv
/*
 * testbench for the manycore column slice
 * host commands from the stimulus file, reference memory model,
 * in-order load response checks and an in-flight bound check
 */

module tb_manycore_link
  import manycore_pkg::*;
();

  localparam int ready_timeout_lp = 200;
  localparam int drain_timeout_lp = 1000;
  localparam int max_gap_lp       = 6;

  logic                        clk;
  logic                        rst_i;
  logic                        cmd_v_i;
  packet_op_e                  cmd_op_i;
  logic [addr_width_lp-1:0]    cmd_addr_i;
  logic [data_width_lp-1:0]    cmd_data_i;
  logic [mask_width_lp-1:0]    cmd_mask_i;
  logic                        cmd_ready_o;
  logic                        resp_v_o;
  logic [data_width_lp-1:0]    resp_data_o;
  logic [load_id_width_lp-1:0] resp_load_id_o;

  // reference model state
  logic [data_width_lp-1:0]    ref_mem [0:dmem_words_lp-1];
  logic [data_width_lp-1:0]    exp_data_q [$];
  logic [load_id_width_lp-1:0] exp_id_q [$];
  logic [load_id_width_lp-1:0] next_id;

  integer         seed;
  integer         fd;
  integer         n;
  integer         got_line;
  int             tries;
  logic [8*128-1:0] line;
  logic [31:0]    f_op;
  logic [31:0]    f_addr;
  logic [31:0]    f_data;
  logic [31:0]    f_mask;
  int             f_gap;

  tb_clock_gen i_clk (
    .clk_o (clk)
  );

  manycore_link_top i_dut (
    .clk            (clk),
    .rst_i          (rst_i),
    .cmd_v_i        (cmd_v_i),
    .cmd_op_i       (cmd_op_i),
    .cmd_addr_i     (cmd_addr_i),
    .cmd_data_i     (cmd_data_i),
    .cmd_mask_i     (cmd_mask_i),
    .cmd_ready_o    (cmd_ready_o),
    .resp_v_o       (resp_v_o),
    .resp_data_o    (resp_data_o),
    .resp_load_id_o (resp_load_id_o)
  );

  task automatic fail_run(input string why);
    $display("%s", why);
    $display("Simulation FAILED");
    $fatal(1);
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      fail_run($sformatf("[ERROR] %0t %s: got 0x%08h, expected 0x%08h",
                         $time, name, got, exp));
    end
  endtask

  // drives at a falling edge, returns at the falling edge after acceptance
  task automatic send_cmd(input logic op, input logic [addr_width_lp-1:0] addr,
                          input logic [data_width_lp-1:0] data,
                          input logic [mask_width_lp-1:0] mask);
    int waited;
    waited     = 0;
    cmd_v_i    = 1'b1;
    cmd_op_i   = packet_op_e'(op);
    cmd_addr_i = addr;
    cmd_data_i = data;
    cmd_mask_i = mask;
    while (!cmd_ready_o) begin
      @(negedge clk);
      waited++;
      if (waited > ready_timeout_lp) begin
        fail_run("timeout: cmd_ready_o stayed low while a command was waiting");
      end
    end
    @(negedge clk);  // taken at the rising edge in between
    if (packet_op_e'(op) == op_store) begin
      for (int i = 0; i < mask_width_lp; i++) begin
        if (mask[i]) ref_mem[addr][8*i +: 8] = data[8*i +: 8];
      end
    end else begin
      exp_data_q.push_back(ref_mem[addr]);
      exp_id_q.push_back(next_id);
      next_id++;  // wraps mod 16
    end
  endtask

  // response monitor; stores count as answered once accepted
  always @(negedge clk) begin
    if (!rst_i) begin
      if (resp_v_o) begin
        if (exp_data_q.size() == 0) begin
          fail_run("a load response arrived with no load pending");
        end else begin
          check_equal("resp_data_o", resp_data_o, exp_data_q.pop_front());
          check_equal("resp_load_id_o", resp_load_id_o, exp_id_q.pop_front());
        end
      end
      if (exp_data_q.size() > max_credits_lp) begin
        fail_run("more loads in flight than the credit limit allows");
      end
    end
  end

  initial begin
    seed       = 32'h3935;
    rst_i      = 1'b1;
    cmd_v_i    = 1'b0;
    cmd_op_i   = op_store;
    cmd_addr_i = '0;
    cmd_data_i = '0;
    cmd_mask_i = '0;
    next_id    = '0;
    repeat (8) @(negedge clk);
    rst_i = 1'b0;
    @(negedge clk);
    check_equal("cmd_ready_o", cmd_ready_o, 1);
    check_equal("resp_v_o", resp_v_o, 0);

    fd = $fopen("stim_manycore_link.txt", "r");
    if (fd == 0) begin
      fail_run("could not open the stimulus file stim_manycore_link.txt");
    end
    while (!$feof(fd)) begin
      line     = '0;
      got_line = $fgets(line, fd);
      n = $sscanf(line, "%h %h %h %h %d", f_op, f_addr, f_data, f_mask, f_gap);
      if (got_line != 0 && n == 5) begin  // header and blank lines fall through
        send_cmd(f_op[0], f_addr[addr_width_lp-1:0], f_data, f_mask[mask_width_lp-1:0]);
        if (f_gap == 9) f_gap = $unsigned($random(seed)) % max_gap_lp;
        if (f_gap != 0) begin
          cmd_v_i = 1'b0;
          repeat (f_gap) @(negedge clk);
        end
      end
    end
    $fclose(fd);
    cmd_v_i = 1'b0;

    tries = 0;
    while (exp_data_q.size() != 0 && tries < drain_timeout_lp) begin
      @(negedge clk);
      tries++;
    end
    if (exp_data_q.size() != 0) begin
      fail_run($sformatf("timeout: %0d load responses never arrived", exp_data_q.size()));
    end else begin
      repeat (10) @(negedge clk);  // room for a stray response
      $display("Simulation PASSED");
      $finish;
    end
  end

endmodule

//--- stim_manycore_link.txt
# op (0 store, 1 load)  addr (hex word)  data (hex)  mask (hex)  gap (cycles, 9 = random)
# data and mask are ignored on loads
0 010 deadbeef f 2
1 010 00000000 0 3
0 011 11223344 f 0
0 011 aabbccdd 1 0
0 011 000000ee 0 1
1 011 00000000 0 2
0 012 01020304 f 0
0 012 a0b0c0d0 6 1
1 012 00000000 0 0
0 013 ffffffff f 0
0 013 00000000 a 0
1 013 00000000 0 1
0 3ff cafef00d f 0
0 000 12345678 f 6
1 010 00000000 0 0
1 011 00000000 0 0
1 012 00000000 0 0
1 013 00000000 0 0
1 3ff 00000000 0 0
1 000 00000000 0 0
1 010 00000000 0 0
1 011 00000000 0 9
0 020 55aa55aa f 9
0 020 00112233 c 9
1 020 00000000 0 9
0 3ff 00000000 3 9
1 3ff 00000000 0 9
0 100 76543210 f 9
1 100 00000000 0 9
1 010 00000000 0 9
0 010 99887766 8 9
1 010 00000000 0 9
1 011 00000000 0 0
1 012 00000000 0 0
1 020 00000000 0 9

//--- src.f
manycore_pkg.sv
manycore_packet_fifo.sv
manycore_io_loader.sv
manycore_tile_endpoint.sv
manycore_link_top.sv
tb_clock_gen.sv
tb_manycore_link.sv

//--- Bender.yml
package:
  name: manycore_link

sources:
  - files:
      - manycore_pkg.sv
      - manycore_packet_fifo.sv
      - manycore_io_loader.sv
      - manycore_tile_endpoint.sv
      - manycore_link_top.sv
  - target: test
    files:
      - tb_clock_gen.sv
      - tb_manycore_link.sv
